//--- common/fb_pkg.sv
// Frame-buffer controller constants and shared vector types.
package fb_pkg;

    // ------------------------------------------------------------
    // Burst format
    // ------------------------------------------------------------
    localparam int DATA_W      = 32;                   // Beat and pixel word width.
    localparam int BURST_LEN   = 16;                   // Beats per INCR burst.
    localparam int BURST_BYTES = BURST_LEN * DATA_W / 8;

    // ------------------------------------------------------------
    // Buffer region
    // ------------------------------------------------------------
    localparam int NUM_SLOTS  = 4;
    localparam int SLOT_IDX_W = $clog2(NUM_SLOTS);
    localparam int SLOT_BITS  = 12;                    // 4 KiB per slot.

    localparam logic [31:0] BASE_ADDR = 32'h1000_0000;
    localparam int DEFAULT_FRAME_BYTES = 1000;         // Used when the configured size is zero.

    // ------------------------------------------------------------
    // FIFO and timing
    // ------------------------------------------------------------
    localparam int FIFO_DEPTH = 64;
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH) + 1;

    localparam int RD_START_DELAY  = 16;               // Cycles from restart to first AR.
    localparam int DLY_CNT_W       = $clog2(RD_START_DELAY + 1);
    localparam int EOF_HOLD_CYCLES = 2;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [31:0]           addr_t;
    typedef logic [SLOT_BITS-1:0]  offs_t;
    typedef logic [SLOT_IDX_W-1:0] slot_t;
    typedef logic [FIFO_CNT_W-1:0] fcnt_t;

endpackage

//--- design/frame_fifo.sv
// Synchronous show-ahead FIFO with burst-sized low and high thresholds.
`timescale 1ns/1ps

module frame_fifo (
    input  logic          axi_clk,
    input  logic          r_rfifo_rst,
    input  logic          clear_i,
    input  logic          push_i,
    input  fb_pkg::data_t push_data_i,
    input  logic          pop_i,
    output fb_pkg::data_t head_o,
    output logic          empty_o,
    output logic          below_burst_o,
    output logic          no_room_o
);
    import fb_pkg::*;

    data_t                         mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    fcnt_t                         cnt;
    logic                          do_push;
    logic                          do_pop;

    assign do_push = push_i && (cnt != fcnt_t'(FIFO_DEPTH));   // Full drops the word.
    assign do_pop  = pop_i && (cnt != '0);

    always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
        if (r_rfifo_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else if (clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            cnt <= cnt + fcnt_t'(do_push) - fcnt_t'(do_pop);
        end
    end

    // Storage array.
    always_ff @(posedge axi_clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data_i;
    end

    assign head_o        = mem[rd_ptr];                         // Show-ahead head word.
    assign empty_o       = (cnt == '0);
    assign below_burst_o = (cnt < fcnt_t'(BURST_LEN));
    assign no_room_o     = (cnt > fcnt_t'(FIFO_DEPTH - BURST_LEN)); // Less than a burst free.

endmodule

//--- buffer_sched/buffer_sched.sv
// Four-slot buffer rotation keeping the writer and the reader apart.
`timescale 1ns/1ps

module buffer_sched (
    input  logic          axi_clk,
    input  logic          r_rfifo_rst,
    input  logic          wr_frame_done_i,
    input  logic          rd_frame_adv_i,
    output fb_pkg::slot_t wr_slot_o,
    output fb_pkg::slot_t rd_slot_o
);
    import fb_pkg::*;

    slot_t wr_slot;
    slot_t rd_slot;
    slot_t last_done;      // Most recently completed write slot.
    slot_t wr_plus1;
    slot_t wr_next;

    // Skip over the slot the reader is using.
    assign wr_plus1 = wr_slot + 1'b1;
    assign wr_next  = (wr_plus1 == rd_slot) ? wr_slot + 2'd2 : wr_plus1;

    always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
        if (r_rfifo_rst) begin
            wr_slot   <= slot_t'(0);
            rd_slot   <= slot_t'(2);
            last_done <= slot_t'(0);
        end else begin
            case ({rd_frame_adv_i, wr_frame_done_i})
                2'b01: begin
                    last_done <= wr_slot;
                    wr_slot   <= wr_next;
                end
                2'b10: begin
                    rd_slot <= last_done;
                end
                2'b11: begin
                    rd_slot   <= wr_slot;     // Hand the frame just written to the reader.
                    last_done <= wr_slot;
                    wr_slot   <= wr_next;
                end
                default: ;
            endcase
        end
    end

    assign wr_slot_o = wr_slot;
    assign rd_slot_o = rd_slot;

endmodule

//--- axi_writer/axi_writer.sv
// AXI4 write engine that drains the pixel FIFO as fixed INCR bursts.
`timescale 1ns/1ps

module axi_writer (
    input  logic          axi_clk,
    input  logic          r_rfifo_rst,
    input  logic          wframe_vsync_i,
    input  fb_pkg::slot_t wr_slot_i,
    input  fb_pkg::data_t fifo_head_i,
    input  logic          fifo_empty_i,
    input  logic          fifo_below_burst_i,
    output logic          fifo_pop_o,
    output logic          fifo_clear_o,
    output logic          wr_frame_done_o,
    output fb_pkg::addr_t awaddr_o,
    output logic          awvalid_o,
    input  logic          awready_i,
    output fb_pkg::data_t wdata_o,
    output logic          wlast_o,
    output logic          wvalid_o,
    input  logic          wready_i
);
    import fb_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_ADV,
        WR_EOF
    } wr_state_t;

    wr_state_t                    state;
    offs_t                        offset;       // Byte offset inside the slot.
    logic [$clog2(BURST_LEN)-1:0] beat_cnt;     // Also times the EOF hold.
    logic [1:0]                   vsync_sr;
    logic                         eof_pending;
    logic                         start_burst;

    // Full burst ready, or a partial one to flush at end of frame.
    assign start_burst = !fifo_below_burst_i || (eof_pending && !fifo_empty_i);

    // ------------------------------------------------------------
    // Write FSM
    // ------------------------------------------------------------
    always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
        if (r_rfifo_rst) begin
            state           <= WR_IDLE;
            offset          <= '0;
            beat_cnt        <= '0;
            vsync_sr        <= '0;
            eof_pending     <= 1'b0;
            awvalid_o       <= 1'b0;
            wvalid_o        <= 1'b0;
            wr_frame_done_o <= 1'b0;
            fifo_clear_o    <= 1'b0;
        end else begin
            vsync_sr        <= {vsync_sr[0], wframe_vsync_i};
            wr_frame_done_o <= 1'b0;
            fifo_clear_o    <= 1'b0;

            if (vsync_sr == 2'b10)
                eof_pending <= 1'b1;            // VSYNC fell.
            if (awvalid_o && awready_i)
                awvalid_o <= 1'b0;

            case (state)
                WR_IDLE: begin
                    beat_cnt <= '0;
                    if (start_burst) begin
                        awvalid_o <= 1'b1;
                        wvalid_o  <= 1'b1;
                        state     <= WR_DATA;
                    end else if (eof_pending) begin
                        wr_frame_done_o <= 1'b1;
                        fifo_clear_o    <= 1'b1;
                        offset          <= '0;
                        state           <= WR_EOF;
                    end
                end
                WR_DATA: begin
                    if (wready_i) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (wlast_o) begin
                            wvalid_o <= 1'b0;
                            state    <= WR_ADV;
                        end
                    end
                end
                WR_ADV: begin
                    // Hold the address until AW has been taken.
                    if (!awvalid_o || awready_i) begin
                        offset <= offset + offs_t'(BURST_BYTES);
                        state  <= WR_IDLE;
                    end
                end
                WR_EOF: begin
                    eof_pending <= 1'b0;
                    beat_cnt    <= beat_cnt + 1'b1;
                    if (beat_cnt == EOF_HOLD_CYCLES - 1)
                        state <= WR_IDLE;
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    assign awaddr_o   = BASE_ADDR + (addr_t'(wr_slot_i) << SLOT_BITS) + addr_t'(offset);
    assign wdata_o    = fifo_empty_i ? '0 : fifo_head_i;   // Zero pad past the last word.
    assign wlast_o    = (beat_cnt == BURST_LEN - 1);
    assign fifo_pop_o = wvalid_o && wready_i;

endmodule

//--- axi_reader/axi_reader.sv
// AXI4 read engine that streams the last finished frame into the read FIFO.
`timescale 1ns/1ps

module axi_reader (
    input  logic          axi_clk,
    input  logic          r_rfifo_rst,
    input  logic          rframe_vsync_i,
    input  fb_pkg::addr_t cfg_frame_bytes_i,
    input  fb_pkg::slot_t rd_slot_i,
    input  logic          fifo_no_room_i,
    output logic          fifo_push_o,
    output fb_pkg::data_t fifo_push_data_o,
    output logic          fifo_clear_o,
    output logic          rd_frame_adv_o,
    output fb_pkg::addr_t araddr_o,
    output logic          arvalid_o,
    input  logic          arready_i,
    input  fb_pkg::data_t rdata_i,
    input  logic          rlast_i,
    input  logic          rvalid_i,
    output logic          rready_o
);
    import fb_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    rd_state_t            state;
    offs_t                offset;
    logic [DLY_CNT_W-1:0] dly_cnt;
    logic                 vsync_d;
    logic                 restart;
    addr_t                frame_cfg;
    addr_t                frame_aligned;
    addr_t                last_offs;

    // ------------------------------------------------------------
    // Frame size, rounded up to whole bursts
    // ------------------------------------------------------------
    assign frame_cfg = (cfg_frame_bytes_i != '0) ? cfg_frame_bytes_i
                                                 : addr_t'(DEFAULT_FRAME_BYTES);
    assign frame_aligned = (frame_cfg + addr_t'(BURST_BYTES - 1)) & ~addr_t'(BURST_BYTES - 1);
    assign last_offs     = frame_aligned - addr_t'(BURST_BYTES);

    // Restart on the falling edge of the display VSYNC.
    assign restart      = vsync_d && !rframe_vsync_i;
    assign fifo_clear_o = restart;

    always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
        if (r_rfifo_rst) begin
            vsync_d        <= 1'b0;
            rd_frame_adv_o <= 1'b0;
            dly_cnt        <= DLY_CNT_W'(RD_START_DELAY);
        end else begin
            vsync_d        <= rframe_vsync_i;
            rd_frame_adv_o <= restart;
            if (restart)
                dly_cnt <= DLY_CNT_W'(RD_START_DELAY);
            else if (dly_cnt != '0)
                dly_cnt <= dly_cnt - 1'b1;
        end
    end

    // ------------------------------------------------------------
    // AR FSM, one burst in flight
    // ------------------------------------------------------------
    always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
        if (r_rfifo_rst) begin
            state     <= RD_IDLE;
            offset    <= '0;
            arvalid_o <= 1'b0;
        end else begin
            case (state)
                RD_IDLE: begin
                    // The push check covers the last beat still on its way in.
                    if (dly_cnt == '0 && !fifo_no_room_i && !fifo_push_o &&
                        frame_aligned != '0) begin
                        arvalid_o <= 1'b1;
                        state     <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (arready_i) begin
                        arvalid_o <= 1'b0;
                        state     <= RD_DATA;
                        if (addr_t'(offset) >= last_offs)
                            offset <= '0;                      // Wrap at frame end.
                        else
                            offset <= offset + offs_t'(BURST_BYTES);
                    end
                end
                RD_DATA: begin
                    if (rvalid_i && rlast_i)
                        state <= RD_IDLE;
                end
                default: state <= RD_IDLE;
            endcase
            if (restart)
                offset <= '0;
        end
    end

    assign araddr_o = BASE_ADDR + (addr_t'(rd_slot_i) << SLOT_BITS) + addr_t'(offset);
    assign rready_o = 1'b1;

    // R beats go into the FIFO one cycle later.
    always_ff @(posedge axi_clk or posedge r_rfifo_rst) begin
        if (r_rfifo_rst)
            fifo_push_o <= 1'b0;
        else
            fifo_push_o <= rvalid_i;
    end

    always_ff @(posedge axi_clk) begin
        fifo_push_data_o <= rdata_i;
    end

endmodule

//--- design/fb_ctrl_top.sv
// Frame-buffer controller top: pixel FIFOs, slot scheduler and AXI4 engines.
`timescale 1ns/1ps

module fb_ctrl_top (
    input  logic          axi_clk,
    input  logic          r_rfifo_rst,
    input  logic          wframe_vsync_i,
    input  logic          wframe_data_en_i,
    input  fb_pkg::data_t wframe_data_i,
    input  logic          rframe_vsync_i,
    input  logic          rframe_data_en_i,
    output fb_pkg::data_t rframe_data_o,
    output logic          rframe_empty_o,
    input  fb_pkg::addr_t cfg_frame_bytes_i,
    output fb_pkg::addr_t awaddr_o,
    output logic          awvalid_o,
    input  logic          awready_i,
    output fb_pkg::data_t wdata_o,
    output logic          wlast_o,
    output logic          wvalid_o,
    input  logic          wready_i,
    output fb_pkg::addr_t araddr_o,
    output logic          arvalid_o,
    input  logic          arready_i,
    input  fb_pkg::data_t rdata_i,
    input  logic          rlast_i,
    input  logic          rvalid_i,
    output logic          rready_o
);
    import fb_pkg::*;

    data_t wr_fifo_head;
    logic  wr_fifo_empty;
    logic  wr_fifo_below_burst;
    logic  wr_fifo_pop;
    logic  wr_fifo_clear;
    logic  rd_fifo_push;
    data_t rd_fifo_push_data;
    logic  rd_fifo_clear;
    logic  rd_fifo_no_room;
    logic  wr_frame_done;
    logic  rd_frame_adv;
    slot_t wr_slot;
    slot_t rd_slot;

    // ------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------
    frame_fifo wr_fifo_inst (
        .axi_clk       (axi_clk),
        .r_rfifo_rst   (r_rfifo_rst),
        .clear_i       (wr_fifo_clear),
        .push_i        (wframe_data_en_i),
        .push_data_i   (wframe_data_i),
        .pop_i         (wr_fifo_pop),
        .head_o        (wr_fifo_head),
        .empty_o       (wr_fifo_empty),
        .below_burst_o (wr_fifo_below_burst),
        .no_room_o     ()
    );

    axi_writer axi_writer_inst (
        .axi_clk            (axi_clk),
        .r_rfifo_rst        (r_rfifo_rst),
        .wframe_vsync_i     (wframe_vsync_i),
        .wr_slot_i          (wr_slot),
        .fifo_head_i        (wr_fifo_head),
        .fifo_empty_i       (wr_fifo_empty),
        .fifo_below_burst_i (wr_fifo_below_burst),
        .fifo_pop_o         (wr_fifo_pop),
        .fifo_clear_o       (wr_fifo_clear),
        .wr_frame_done_o    (wr_frame_done),
        .awaddr_o           (awaddr_o),
        .awvalid_o          (awvalid_o),
        .awready_i          (awready_i),
        .wdata_o            (wdata_o),
        .wlast_o            (wlast_o),
        .wvalid_o           (wvalid_o),
        .wready_i           (wready_i)
    );

    buffer_sched buffer_sched_inst (
        .axi_clk         (axi_clk),
        .r_rfifo_rst     (r_rfifo_rst),
        .wr_frame_done_i (wr_frame_done),
        .rd_frame_adv_i  (rd_frame_adv),
        .wr_slot_o       (wr_slot),
        .rd_slot_o       (rd_slot)
    );

    // ------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------
    axi_reader axi_reader_inst (
        .axi_clk           (axi_clk),
        .r_rfifo_rst       (r_rfifo_rst),
        .rframe_vsync_i    (rframe_vsync_i),
        .cfg_frame_bytes_i (cfg_frame_bytes_i),
        .rd_slot_i         (rd_slot),
        .fifo_no_room_i    (rd_fifo_no_room),
        .fifo_push_o       (rd_fifo_push),
        .fifo_push_data_o  (rd_fifo_push_data),
        .fifo_clear_o      (rd_fifo_clear),
        .rd_frame_adv_o    (rd_frame_adv),
        .araddr_o          (araddr_o),
        .arvalid_o         (arvalid_o),
        .arready_i         (arready_i),
        .rdata_i           (rdata_i),
        .rlast_i           (rlast_i),
        .rvalid_i          (rvalid_i),
        .rready_o          (rready_o)
    );

    frame_fifo rd_fifo_inst (
        .axi_clk       (axi_clk),
        .r_rfifo_rst   (r_rfifo_rst),
        .clear_i       (rd_fifo_clear),
        .push_i        (rd_fifo_push),
        .push_data_i   (rd_fifo_push_data),
        .pop_i         (rframe_data_en_i),     // Ignored while empty.
        .head_o        (rframe_data_o),
        .empty_o       (rframe_empty_o),
        .below_burst_o (),
        .no_room_o     (rd_fifo_no_room)
    );

endmodule

//--- verif/axi_mem_model.sv
// AXI4 slave memory for the testbench with random ready stalls and address logs.
`timescale 1ns/1ps

module axi_mem_model #(
    parameter logic [31:0] SEED = 32'd1
) (
    input  logic          axi_clk,
    input  logic          r_rfifo_rst,
    input  fb_pkg::addr_t awaddr_i,
    input  logic          awvalid_i,
    output logic          awready_o,
    input  fb_pkg::data_t wdata_i,
    input  logic          wlast_i,
    input  logic          wvalid_i,
    output logic          wready_o,
    input  fb_pkg::addr_t araddr_i,
    input  logic          arvalid_i,
    output logic          arready_o,
    output fb_pkg::data_t rdata_o,
    output logic          rlast_o,
    output logic          rvalid_o,
    input  logic          rready_i
);
    import fb_pkg::*;

    data_t       mem [addr_t];          // Sparse, keyed by byte address.
    addr_t       aw_q[$];
    data_t       w_q[$];
    addr_t       ar_q[$];
    addr_t       aw_log[$];             // Every accepted AW address, in order.
    addr_t       ar_log[$];             // Every accepted AR address, in order.
    addr_t       commit_addr;
    int          w_beat;
    int          r_beat;
    int          wlast_errs;
    logic [31:0] rng;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Unwritten words read back as a pattern of their own address.
    function automatic data_t peek_word(input addr_t a);
        if (mem.exists(a))
            return mem[a];
        return ~a ^ 32'h5a5a_0000;
    endfunction

    // ------------------------------------------------------------
    // Handshakes, sampled on the rising edge
    // ------------------------------------------------------------
    always @(posedge axi_clk) begin
        if (r_rfifo_rst) begin
            aw_q.delete();
            w_q.delete();
            ar_q.delete();
            w_beat     = 0;
            r_beat     = 0;
            wlast_errs = 0;
        end else begin
            if (awvalid_i && awready_o) begin
                aw_q.push_back(awaddr_i);
                aw_log.push_back(awaddr_i);
            end
            if (wvalid_i && wready_o) begin
                if (wlast_i != (w_beat == BURST_LEN - 1))
                    wlast_errs++;
                w_beat = (w_beat == BURST_LEN - 1) ? 0 : w_beat + 1;
                w_q.push_back(wdata_i);
            end
            if (arvalid_i && arready_o) begin
                ar_q.push_back(araddr_i);
                ar_log.push_back(araddr_i);
            end
            if (rvalid_o && rready_i) begin
                if (rlast_o) begin
                    r_beat = 0;
                    void'(ar_q.pop_front());
                end else begin
                    r_beat++;
                end
            end
            // W beats may run ahead of AW, so commit whole bursts only.
            while (aw_q.size() > 0 && w_q.size() >= BURST_LEN) begin
                commit_addr = aw_q.pop_front();
                for (int i = 0; i < BURST_LEN; i++)
                    mem[commit_addr + addr_t'(i * 4)] = w_q.pop_front();
            end
        end
    end

    // ------------------------------------------------------------
    // Ready and R outputs, driven on the falling edge
    // ------------------------------------------------------------
    initial begin
        rng       = SEED;
        awready_o = 1'b0;
        wready_o  = 1'b0;
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        rlast_o   = 1'b0;
        rdata_o   = '0;
        forever begin
            @(negedge axi_clk);
            rng = xorshift(rng);
            if (r_rfifo_rst) begin
                awready_o = 1'b0;
                wready_o  = 1'b0;
                arready_o = 1'b0;
                rvalid_o  = 1'b0;
                rlast_o   = 1'b0;
            end else begin
                awready_o = (rng[1:0] != 2'b00);     // Stall about one cycle in four.
                wready_o  = (rng[3:2] != 2'b00);
                arready_o = (rng[5:4] != 2'b00);
                if (ar_q.size() > 0 && rng[7:6] != 2'b00) begin
                    rvalid_o = 1'b1;
                    rdata_o  = peek_word(ar_q[0] + addr_t'(r_beat * 4));
                    rlast_o  = (r_beat == BURST_LEN - 1);
                end else begin
                    rvalid_o = 1'b0;
                    rlast_o  = 1'b0;
                end
            end
        end
    end

endmodule

//--- verif/tb_fb_ctrl.sv
// Testbench for the frame-buffer controller against an AXI4 memory model.
`timescale 1ns/1ps

module tb_fb_ctrl;
    import fb_pkg::*;

    localparam int WAIT_LIMIT = 4000;

    logic  axi_clk;
    logic  r_rfifo_rst;
    logic  wframe_vsync;
    logic  wframe_data_en;
    data_t wframe_data;
    logic  rframe_vsync;
    logic  rframe_data_en;
    data_t rframe_data;
    logic  rframe_empty;
    addr_t cfg_frame_bytes;
    addr_t awaddr;
    logic  awvalid;
    logic  awready;
    data_t wdata;
    logic  wlast;
    logic  wvalid;
    logic  wready;
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    data_t rdata;
    logic  rlast;
    logic  rvalid;
    logic  rready;

    // Reference model state.
    slot_t       wr_m;
    slot_t       rd_m;
    slot_t       last_m;
    int          ar_base;          // First AR log entry of the current read frame.
    int          rd_words;
    int          rd_bursts;
    int          checks;
    int          errors;
    logic [31:0] rng;
    data_t       pix_q[$];

    fb_ctrl_top fb_ctrl_top_inst (
        .axi_clk           (axi_clk),
        .r_rfifo_rst       (r_rfifo_rst),
        .wframe_vsync_i    (wframe_vsync),
        .wframe_data_en_i  (wframe_data_en),
        .wframe_data_i     (wframe_data),
        .rframe_vsync_i    (rframe_vsync),
        .rframe_data_en_i  (rframe_data_en),
        .rframe_data_o     (rframe_data),
        .rframe_empty_o    (rframe_empty),
        .cfg_frame_bytes_i (cfg_frame_bytes),
        .awaddr_o          (awaddr),
        .awvalid_o         (awvalid),
        .awready_i         (awready),
        .wdata_o           (wdata),
        .wlast_o           (wlast),
        .wvalid_o          (wvalid),
        .wready_i          (wready),
        .araddr_o          (araddr),
        .arvalid_o         (arvalid),
        .arready_i         (arready),
        .rdata_i           (rdata),
        .rlast_i           (rlast),
        .rvalid_i          (rvalid),
        .rready_o          (rready)
    );

    axi_mem_model #(.SEED(32'd16567)) axi_mem_model_inst (
        .axi_clk     (axi_clk),
        .r_rfifo_rst (r_rfifo_rst),
        .awaddr_i    (awaddr),
        .awvalid_i   (awvalid),
        .awready_o   (awready),
        .wdata_i     (wdata),
        .wlast_i     (wlast),
        .wvalid_i    (wvalid),
        .wready_o    (wready),
        .araddr_i    (araddr),
        .arvalid_i   (arvalid),
        .arready_o   (arready),
        .rdata_o     (rdata),
        .rlast_o     (rlast),
        .rvalid_o    (rvalid),
        .rready_i    (rready)
    );

    initial begin
        axi_clk = 1'b0;
        forever #4 axi_clk = ~axi_clk;     // 8 ns period.
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic addr_t slot_addr(input slot_t s, input int offs);
        return BASE_ADDR + addr_t'(s) * addr_t'(1 << SLOT_BITS) + addr_t'(offs);
    endfunction

    function automatic int align_frame(input addr_t cfg);
        int bytes;
        bytes = (cfg == '0) ? DEFAULT_FRAME_BYTES : int'(cfg);
        return ((bytes + BURST_BYTES - 1) / BURST_BYTES) * BURST_BYTES;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        errors++;
        $display("%s", why);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("*** FAILED ***");
        $fatal(1, "Run aborted");
    endtask

    task automatic wait_frame_done();
        int waited;
        waited = 0;
        while (!fb_ctrl_top_inst.wr_frame_done && waited < WAIT_LIMIT) begin
            @(negedge axi_clk);
            waited++;
        end
        if (!fb_ctrl_top_inst.wr_frame_done)
            abort_run("Timed out waiting for the end of a write frame");
    endtask

    // Reader idle with a full FIFO and no burst outstanding.
    task automatic wait_read_quiet();
        int waited;
        waited = 0;
        while (!(fb_ctrl_top_inst.rd_fifo_no_room && !arvalid &&
                 axi_mem_model_inst.ar_q.size() == 0) && waited < WAIT_LIMIT) begin
            @(negedge axi_clk);
            waited++;
        end
        if (waited >= WAIT_LIMIT)
            abort_run("Timed out waiting for the read FIFO to fill");
    endtask

    // ------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------
    task automatic write_frame(input int nwords);
        int    aw_base;
        int    nbursts;
        slot_t slot;
        aw_base = axi_mem_model_inst.aw_log.size();
        nbursts = (nwords + BURST_LEN - 1) / BURST_LEN;
        pix_q.delete();
        wframe_vsync = 1'b1;
        for (int i = 0; i < nwords; i++) begin
            repeat (1 + rand32() % 3) @(negedge axi_clk);
            wframe_data_en = 1'b1;
            wframe_data    = rand32();
            pix_q.push_back(wframe_data);
            @(negedge axi_clk);
            wframe_data_en = 1'b0;
        end
        repeat (3) @(negedge axi_clk);
        wframe_vsync = 1'b0;
        wait_frame_done();
        @(negedge axi_clk);
        check_eq("wr_frame_done", fb_ctrl_top_inst.wr_frame_done, 32'h0);

        slot   = wr_m;
        last_m = wr_m;
        wr_m   = (slot_t'(wr_m + 1) == rd_m) ? slot_t'(wr_m + 2) : slot_t'(wr_m + 1);

        check_eq("aw burst count", axi_mem_model_inst.aw_log.size() - aw_base, nbursts);
        for (int k = 0; k < nbursts; k++)
            check_eq("awaddr_o", axi_mem_model_inst.aw_log[aw_base + k],
                     slot_addr(slot, k * BURST_BYTES));
        // Tail of the last burst is zero padded.
        for (int i = 0; i < nbursts * BURST_LEN; i++)
            check_eq("memory word", axi_mem_model_inst.peek_word(slot_addr(slot, i * 4)),
                     (i < nwords) ? pix_q[i] : 32'h0);
    endtask

    // ------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------
    task automatic restart_read(input addr_t cfg);
        wait_read_quiet();
        cfg_frame_bytes = cfg;
        rframe_vsync    = 1'b1;
        @(negedge axi_clk);
        rframe_vsync = 1'b0;
        @(negedge axi_clk);               // Read FIFO is cleared on this edge.
        ar_base      = axi_mem_model_inst.ar_log.size();
        rd_m         = last_m;
        rd_words     = 0;
        rd_bursts    = align_frame(cfg) / BURST_BYTES;
    endtask

    task automatic drain_words(input int count);
        int waited;
        int burst;
        for (int n = 0; n < count; n++) begin
            waited = 0;
            while (rframe_empty && waited < WAIT_LIMIT) begin
                @(negedge axi_clk);
                waited++;
            end
            if (rframe_empty)
                abort_run("Timed out waiting for read data");
            burst = (rd_words / BURST_LEN) % rd_bursts;      // Wraps at the frame end.
            check_eq("rframe_data_o", rframe_data, axi_mem_model_inst.peek_word(
                     slot_addr(rd_m, burst * BURST_BYTES + (rd_words % BURST_LEN) * 4)));
            rd_words++;
            rframe_data_en = 1'b1;
            @(negedge axi_clk);
            rframe_data_en = 1'b0;
            if (rand32() % 4 == 0)
                @(negedge axi_clk);
        end
    endtask

    task automatic check_ar_log();
        int n;
        n = axi_mem_model_inst.ar_log.size() - ar_base;
        for (int k = 0; k < n; k++)
            check_eq("araddr_o", axi_mem_model_inst.ar_log[ar_base + k],
                     slot_addr(rd_m, (k % rd_bursts) * BURST_BYTES));
    endtask

    task automatic report();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        rng             = 32'd16567;
        checks          = 0;
        errors          = 0;
        wr_m            = slot_t'(0);
        rd_m            = slot_t'(2);
        last_m          = slot_t'(0);
        r_rfifo_rst     = 1'b1;
        wframe_vsync    = 1'b0;
        wframe_data_en  = 1'b0;
        wframe_data     = '0;
        rframe_vsync    = 1'b0;
        rframe_data_en  = 1'b0;
        cfg_frame_bytes = addr_t'(1 + rand32() % 1000);
        repeat (5) @(negedge axi_clk);
        r_rfifo_rst = 1'b0;
        @(negedge axi_clk);

        check_eq("awvalid_o", awvalid, 32'h0);
        check_eq("wvalid_o", wvalid, 32'h0);
        check_eq("arvalid_o", arvalid, 32'h0);
        check_eq("rframe_empty_o", rframe_empty, 32'h1);
        check_eq("rready_o", rready, 32'h1);

        // Four frames walk the write slot around the read slot.
        for (int f = 0; f < 4; f++)
            write_frame(40 + int'(rand32() % 211));

        restart_read(cfg_frame_bytes);
        drain_words(2 * rd_bursts * BURST_LEN + 8);
        wait_read_quiet();
        check_ar_log();

        restart_read('0);
        drain_words(2 * rd_bursts * BURST_LEN + 8);
        wait_read_quiet();
        check_ar_log();

        check_eq("wlast_o position errors", axi_mem_model_inst.wlast_errs, 32'h0);
        report();
    end

endmodule

//--- compile.f
common/fb_pkg.sv
design/frame_fifo.sv
buffer_sched/buffer_sched.sv
axi_writer/axi_writer.sv
axi_reader/axi_reader.sv
design/fb_ctrl_top.sv
verif/axi_mem_model.sv
verif/tb_fb_ctrl.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_fb_ctrl
FILELIST  = compile.f
PASS_MSG  = *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir
